// ==== hdl/wro_pkg.sv ====
package wro_pkg;

    // ==============================
    // Widths and counts
    // ==============================

    // Byte address width of a request
    localparam int ADDR_BITS = 32;
    // Bits below one 64 byte line are not part of the hash
    localparam int LINE_OFFSET_BITS = 6;
    localparam int HASH_BITS = 6;
    localparam int N_HASH = 1 << HASH_BITS;
    localparam int TAG_BITS = 4;
    localparam int N_TAGS = 1 << TAG_BITS;
    localparam int DATA_BITS = 32;
    // Each channel starts with this many downstream credits
    localparam int CREDITS_INIT = 4;
    localparam int CREDIT_BITS = 3;
    // Number of HASH_BITS wide slices folded into one hash
    localparam int HASH_FOLDS = 4;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [HASH_BITS-1:0] hash_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [CREDIT_BITS-1:0] credit_t;

    // ==============================
    // Request and response types
    // ==============================

    typedef struct packed {
        logic valid;
        addr_t addr;
        tag_t tag;
        logic check_order;
    } rd_req_t;

    // The write request is the read layout with the data word appended
    typedef struct packed {
        logic valid;
        addr_t addr;
        tag_t tag;
        logic check_order;
        data_t data;
    } wr_req_t;

    // Responses carry only the tag and have no back-pressure
    typedef struct packed {
        logic valid;
        tag_t tag;
    } rsp_t;

    // Decision taken for a channel head in one cycle
    typedef enum logic [1:0] {
        ISSUE_IDLE,
        ISSUE_SEND,
        ISSUE_HOLD_CONFLICT,
        ISSUE_HOLD_CREDIT
    } issue_e;

    // Fold the line address into a short hash by XOR of equal slices
    function automatic hash_t hash_addr(input addr_t addr);
        hash_t h;
        h = '0;
        for (int i = 0; i < HASH_FOLDS; i++)
        begin
            h = h ^ addr[LINE_OFFSET_BITS + i * HASH_BITS +: HASH_BITS];
        end
        return h;
    endfunction

endpackage

// ==== hdl/wro_req_buffer.sv ====
`timescale 1ns/1ps

// One-entry request buffer for a single channel. The head is held until
// issue control sends it downstream, and the address hash is computed
// once when the request is loaded so that the filters see a stable value
module wro_req_buffer
(
    input  logic clk,
    input  logic reset,

    // Upstream side with valid in the struct and ready back
    input  wro_pkg::wr_req_t req_in,
    output logic ready,

    // Issue control sends the head downstream in this cycle
    input  logic issue,

    // Held request and its hash
    output wro_pkg::wr_req_t head,
    output wro_pkg::hash_t head_hash
);

    // ==============================
    // Flow control
    // ==============================

    // A new request may enter when the slot is empty or is being
    // vacated in this same cycle
    assign ready = !head.valid || issue;

    logic load;

    // The transfer happens on the edge where valid and ready meet
    assign load = req_in.valid && ready;

    // ==============================
    // Storage
    // ==============================

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            head <= req_in;
            // Hash is registered with the payload so the filter test
            // path starts from a flop
            head_hash <= wro_pkg::hash_addr(req_in.addr);
        end
        else if (issue)
        begin
            // Head left and nothing replaced it
            head.valid <= 1'b0;
        end

        // Reset empties the slot
        if (reset)
        begin
            head.valid <= 1'b0;
        end
    end

endmodule

// ==== hdl/wro_busy_filter.sv ====
`timescale 1ns/1ps

// Busy table with one bit per address hash. A bit is set when a request
// to that hash is issued downstream and cleared when a response comes
// back. Two reads to the same hash share one bit, so a read behind
// another read to the same hash is treated as a conflict
module wro_busy_filter
(
    input  logic clk,
    input  logic reset,

    // Test ports, one for each channel head
    input  wro_pkg::hash_t test_hash_rd,
    input  wro_pkg::hash_t test_hash_wr,
    output logic busy_rd,
    output logic busy_wr,

    // Set a bit when the owning channel issues
    input  logic insert_en,
    input  wro_pkg::hash_t insert_hash,

    // Clear a bit when the owning channel sees a response
    input  logic remove_en,
    input  wro_pkg::hash_t remove_hash
);

    logic [wro_pkg::N_HASH-1:0] busy_bits;

    // ==============================
    // Test
    // ==============================

    // Lookups are combinational so a head sees the table as of the
    // last edge
    assign busy_rd = busy_bits[test_hash_rd];
    assign busy_wr = busy_bits[test_hash_wr];

    // ==============================
    // Update
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy_bits <= '0;
        end
        else
        begin
            if (remove_en)
            begin
                busy_bits[remove_hash] <= 1'b0;
            end
            // Insert comes last so it wins over a remove of the same hash
            if (insert_en)
            begin
                busy_bits[insert_hash] <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/wro_tag_heap.sv ====
`timescale 1ns/1ps

// Tag-indexed store of the hash of each outstanding request. A response
// only carries its tag, so the hash needed to clear the busy filter is
// looked up here
module wro_tag_heap
(
    input  logic clk,

    // Written when the channel issues downstream
    input  logic write_en,
    input  wro_pkg::tag_t write_tag,
    input  wro_pkg::hash_t write_hash,

    // Read by the tag of an incoming response
    input  wro_pkg::tag_t read_tag,
    output wro_pkg::hash_t read_hash
);

    // ==============================
    // Storage
    // ==============================

    // Entries are only meaningful while their tag is outstanding
    wro_pkg::hash_t heap_mem [wro_pkg::N_TAGS];

    always_ff @(posedge clk)
    begin
        if (write_en)
        begin
            heap_mem[write_tag] <= write_hash;
        end
    end

    // The requester never reuses a live tag, so the entry read here
    // is never the one being written in the same cycle
    assign read_hash = heap_mem[read_tag];

endmodule

// ==== hdl/wro_credit_counter.sv ====
`timescale 1ns/1ps

// Downstream credit count for one channel. Memory hands back one credit
// per pulse on credit_return, and every issued request spends one
module wro_credit_counter
(
    input  logic clk,
    input  logic reset,

    // One credit spent at this edge
    input  logic consume,

    // One credit returned at this edge
    input  logic credit_return,

    // At least one credit is left
    output logic available
);

    wro_pkg::credit_t count;

    // ==============================
    // Counter
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            count <= wro_pkg::credit_t'(wro_pkg::CREDITS_INIT);
        end
        else
        begin
            case ({consume, credit_return})
                2'b10:
                begin
                    count <= count - wro_pkg::credit_t'(1);
                end
                2'b01:
                begin
                    count <= count + wro_pkg::credit_t'(1);
                end
                // Spend and return together cancel out
                default:
                begin
                    count <= count;
                end
            endcase
        end
    end

    assign available = (count != '0);

endmodule

// ==== hdl/wro_issue_ctrl.sv ====
`timescale 1ns/1ps

// Decides in each cycle whether each channel head is sent downstream or
// held. An ordered head holds while its hash is busy in either filter.
// Conflicts are checked ahead of credits so a blocked head reports as a
// conflict even when the channel is also out of credit
module wro_issue_ctrl
(
    input  logic clk,
    input  logic reset,

    // Channel heads and their hashes
    input  wro_pkg::rd_req_t rd_head,
    input  wro_pkg::hash_t rd_hash,
    input  wro_pkg::wr_req_t wr_head,
    input  wro_pkg::hash_t wr_hash,

    // Filter lookups named head_busy_in_filter
    input  logic rd_busy_in_rd,
    input  logic rd_busy_in_wr,
    input  logic wr_busy_in_rd,
    input  logic wr_busy_in_wr,

    // Credit state of each channel
    input  logic rd_credit_ok,
    input  logic wr_credit_ok,

    output logic rd_issue,
    output logic wr_issue,
    output logic rd_conflict_event,
    output logic wr_conflict_event
);

    logic rd_conflict;
    logic wr_conflict;
    logic same_cycle_hit;
    wro_pkg::issue_e rd_state;
    wro_pkg::issue_e wr_state;

    // ==============================
    // Conflict detection
    // ==============================

    assign rd_conflict = rd_head.check_order && (rd_busy_in_rd || rd_busy_in_wr);

    // Both heads at the same hash in one cycle. The filters cannot see
    // this yet, so the read is given the slot and the write waits
    assign same_cycle_hit = rd_head.valid && wr_head.valid && (rd_hash == wr_hash);

    assign wr_conflict = wr_head.check_order &&
                         (wr_busy_in_rd || wr_busy_in_wr || same_cycle_hit);

    // ==============================
    // Per-channel decision
    // ==============================

    always_comb
    begin
        if (!rd_head.valid)
            rd_state = wro_pkg::ISSUE_IDLE;
        else if (rd_conflict)
            rd_state = wro_pkg::ISSUE_HOLD_CONFLICT;
        else if (!rd_credit_ok)
            rd_state = wro_pkg::ISSUE_HOLD_CREDIT;
        else
            rd_state = wro_pkg::ISSUE_SEND;
    end

    always_comb
    begin
        if (!wr_head.valid)
            wr_state = wro_pkg::ISSUE_IDLE;
        else if (wr_conflict)
            wr_state = wro_pkg::ISSUE_HOLD_CONFLICT;
        else if (!wr_credit_ok)
            wr_state = wro_pkg::ISSUE_HOLD_CREDIT;
        else
            wr_state = wro_pkg::ISSUE_SEND;
    end

    assign rd_issue = (rd_state == wro_pkg::ISSUE_SEND);
    assign wr_issue = (wr_state == wro_pkg::ISSUE_SEND);

    // ==============================
    // Events
    // ==============================

    // One event per channel, one cycle after the head was held by a conflict
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_conflict_event <= 1'b0;
            wr_conflict_event <= 1'b0;
        end
        else
        begin
            rd_conflict_event <= (rd_state == wro_pkg::ISSUE_HOLD_CONFLICT);
            wr_conflict_event <= (wr_state == wro_pkg::ISSUE_HOLD_CONFLICT);
        end
    end

endmodule

// ==== hdl/wro_shim.sv ====
`timescale 1ns/1ps

// Write/read ordering shim between a requester and a memory port.
// Requests with check_order set are held while an earlier request to the
// same address hash is still outstanding on either channel
module wro_shim
(
    input  logic clk,
    input  logic reset,

    // Upstream requests
    input  wro_pkg::rd_req_t up_rd_req,
    output logic up_rd_ready,
    input  wro_pkg::wr_req_t up_wr_req,
    output logic up_wr_ready,

    // Downstream requests, each valid spends one credit
    output wro_pkg::rd_req_t dn_rd_req,
    output wro_pkg::wr_req_t dn_wr_req,
    input  logic dn_rd_credit,
    input  logic dn_wr_credit,

    // Responses pass straight through
    input  wro_pkg::rsp_t dn_rd_rsp,
    input  wro_pkg::rsp_t dn_wr_rsp,
    output wro_pkg::rsp_t up_rd_rsp,
    output wro_pkg::rsp_t up_wr_rsp,

    output logic rd_conflict_event,
    output logic wr_conflict_event
);

    wro_pkg::wr_req_t rd_req_in;
    wro_pkg::wr_req_t rd_head_full;
    wro_pkg::rd_req_t rd_head;
    wro_pkg::wr_req_t wr_head;
    wro_pkg::hash_t rd_hash;
    wro_pkg::hash_t wr_hash;
    wro_pkg::hash_t rd_rsp_hash;
    wro_pkg::hash_t wr_rsp_hash;
    logic rd_issue;
    logic wr_issue;
    logic rd_busy_in_rd;
    logic rd_busy_in_wr;
    logic wr_busy_in_rd;
    logic wr_busy_in_wr;
    logic rd_credit_ok;
    logic wr_credit_ok;

    // ==============================
    // Input buffers and hashing
    // ==============================

    // The read channel reuses the write layout with an empty data word
    always_comb
    begin
        rd_req_in = '0;
        rd_req_in.valid = up_rd_req.valid;
        rd_req_in.addr = up_rd_req.addr;
        rd_req_in.tag = up_rd_req.tag;
        rd_req_in.check_order = up_rd_req.check_order;
    end

    wro_req_buffer rd_buf (.clk, .reset, .req_in(rd_req_in), .ready(up_rd_ready),
                           .issue(rd_issue), .head(rd_head_full), .head_hash(rd_hash));

    wro_req_buffer wr_buf (.clk, .reset, .req_in(up_wr_req), .ready(up_wr_ready),
                           .issue(wr_issue), .head(wr_head), .head_hash(wr_hash));

    // Drop the unused data word again
    always_comb
    begin
        rd_head.valid = rd_head_full.valid;
        rd_head.addr = rd_head_full.addr;
        rd_head.tag = rd_head_full.tag;
        rd_head.check_order = rd_head_full.check_order;
    end

    // ==============================
    // Busy filters
    // ==============================

    // Each filter tracks its own channel and is tested by both heads
    wro_busy_filter rd_filter (.clk, .reset,
        .test_hash_rd(rd_hash), .test_hash_wr(wr_hash),
        .busy_rd(rd_busy_in_rd), .busy_wr(wr_busy_in_rd),
        .insert_en(rd_issue), .insert_hash(rd_hash),
        .remove_en(dn_rd_rsp.valid), .remove_hash(rd_rsp_hash));

    wro_busy_filter wr_filter (.clk, .reset,
        .test_hash_rd(rd_hash), .test_hash_wr(wr_hash),
        .busy_rd(rd_busy_in_wr), .busy_wr(wr_busy_in_wr),
        .insert_en(wr_issue), .insert_hash(wr_hash),
        .remove_en(dn_wr_rsp.valid), .remove_hash(wr_rsp_hash));

    // ==============================
    // Tag heaps
    // ==============================

    // Remember the hash of each issued tag until its response clears it
    wro_tag_heap rd_heap (.clk, .write_en(rd_issue), .write_tag(rd_head.tag),
        .write_hash(rd_hash), .read_tag(dn_rd_rsp.tag), .read_hash(rd_rsp_hash));

    wro_tag_heap wr_heap (.clk, .write_en(wr_issue), .write_tag(wr_head.tag),
        .write_hash(wr_hash), .read_tag(dn_wr_rsp.tag), .read_hash(wr_rsp_hash));

    // ==============================
    // Credits and issue control
    // ==============================

    wro_credit_counter rd_credits (.clk, .reset, .consume(rd_issue),
        .credit_return(dn_rd_credit), .available(rd_credit_ok));

    wro_credit_counter wr_credits (.clk, .reset, .consume(wr_issue),
        .credit_return(dn_wr_credit), .available(wr_credit_ok));

    wro_issue_ctrl issue_ctrl (.clk, .reset,
        .rd_head, .rd_hash, .wr_head, .wr_hash,
        .rd_busy_in_rd, .rd_busy_in_wr, .wr_busy_in_rd, .wr_busy_in_wr,
        .rd_credit_ok, .wr_credit_ok, .rd_issue, .wr_issue,
        .rd_conflict_event, .wr_conflict_event);

    // Heads go downstream only in the cycle they issue
    always_comb
    begin
        dn_rd_req = rd_head;
        dn_rd_req.valid = rd_issue;
        dn_wr_req = wr_head;
        dn_wr_req.valid = wr_issue;
    end

    // No back-pressure on responses so they are forwarded as they arrive
    assign up_rd_rsp = dn_rd_rsp;
    assign up_wr_rsp = dn_wr_rsp;

endmodule

// ==== testbench/wro_assertions.sv ====
`timescale 1ns/1ps

// Protocol rules on the shim boundary, bound into wro_shim
module wro_assertions
(
    input logic clk,
    input logic reset,
    input wro_pkg::rd_req_t dn_rd_req,
    input wro_pkg::wr_req_t dn_wr_req,
    input logic dn_rd_credit,
    input logic dn_wr_credit,
    input logic rd_conflict_event,
    input logic wr_conflict_event
);

    // High from the second reset edge on, when every flop has been cleared
    logic reset_held = 1'b0;

    // Credits left per channel, counted from the boundary traffic alone
    int rd_credits_left;
    int wr_credits_left;

    always @(posedge clk)
    begin
        reset_held <= reset;
    end

    // Each downstream valid spends one credit and each pulse returns one
    always @(posedge clk)
    begin
        if (reset)
        begin
            rd_credits_left <= wro_pkg::CREDITS_INIT;
            wr_credits_left <= wro_pkg::CREDITS_INIT;
        end
        else
        begin
            rd_credits_left <= rd_credits_left - int'(dn_rd_req.valid) + int'(dn_rd_credit);
            wr_credits_left <= wr_credits_left - int'(dn_wr_req.valid) + int'(dn_wr_credit);
        end
    end

    // ==============================
    // Credit and ordering rules
    // ==============================

    rd_credit_rule: assert property (@(posedge clk) disable iff (reset)
        dn_rd_req.valid |-> (rd_credits_left > 0))
    else
    begin
        $error("read request sent with no credit left");
        wro_tb.assert_fail_count++;
    end

    wr_credit_rule: assert property (@(posedge clk) disable iff (reset)
        dn_wr_req.valid |-> (wr_credits_left > 0))
    else
    begin
        $error("write request sent with no credit left");
        wro_tb.assert_fail_count++;
    end

    // Two ordered requests to one hash never leave in the same cycle
    same_hash_rule: assert property (@(posedge clk) disable iff (reset)
        !(dn_rd_req.valid && dn_wr_req.valid && dn_rd_req.check_order &&
          dn_wr_req.check_order &&
          (wro_pkg::hash_addr(dn_rd_req.addr) == wro_pkg::hash_addr(dn_wr_req.addr))))
    else
    begin
        $error("ordered read and write to the same hash sent together");
        wro_tb.assert_fail_count++;
    end

    // ==============================
    // Reset rule
    // ==============================

    reset_quiet_rule: assert property (@(posedge clk)
        (reset && reset_held) |-> (!dn_rd_req.valid && !dn_wr_req.valid &&
                                   !rd_conflict_event && !wr_conflict_event))
    else
    begin
        $error("request valid or conflict event high during reset");
        wro_tb.assert_fail_count++;
    end

endmodule

// ==== testbench/wro_tb.sv ====
`timescale 1ns/1ps

// Testbench for the write/read ordering shim. A random requester feeds
// both channels, a random memory model returns responses and credits, and
// a cycle model of the ordering rules predicts every downstream issue
module wro_tb;

    // ==============================
    // Run length
    // ==============================

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int DIRECTED_CYCLES = 40;
    localparam int DIRECTED_REQS = 6;
    localparam int RANDOM_CYCLES = 3000;
    localparam int MARGIN_CYCLES = 500;

    logic clk = 1'b0;
    logic reset;
    wro_pkg::rd_req_t up_rd_req;
    logic up_rd_ready;
    wro_pkg::wr_req_t up_wr_req;
    logic up_wr_ready;
    wro_pkg::rd_req_t dn_rd_req;
    wro_pkg::wr_req_t dn_wr_req;
    logic dn_rd_credit;
    logic dn_wr_credit;
    wro_pkg::rsp_t dn_rd_rsp;
    wro_pkg::rsp_t dn_wr_rsp;
    wro_pkg::rsp_t up_rd_rsp;
    wro_pkg::rsp_t up_wr_rsp;
    logic rd_conflict_event;
    logic wr_conflict_event;

    // ==============================
    // Model state, index 0 is the read channel and 1 the write channel
    // ==============================

    integer seed = 32'he689_625e;
    int value_errors = 0;
    int other_errors = 0;
    int assert_fail_count = 0;
    int cycle = 0;
    bit gen_on;
    bit ordered_on;
    bit credits_on;
    int present_limit;
    wro_pkg::wr_req_t req_q [2][$];
    bit busy [2][wro_pkg::N_HASH];
    bit tag_used [2][wro_pkg::N_TAGS];
    wro_pkg::hash_t tag_hash [2][wro_pkg::N_TAGS];
    int rsp_due [2][$];
    wro_pkg::tag_t rsp_tag [2][$];
    int credits [2];
    int owed [2];
    int issued [2];
    int presented [2];
    bit hold_prev [2];
    bit last_ready [2];

    wro_shim DUT (.*);

    bind wro_shim wro_assertions shim_checks (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Line hash as the ordering rule defines it, four 6-bit slices XORed
    function automatic wro_pkg::hash_t line_hash(input wro_pkg::addr_t addr);
        return addr[11:6] ^ addr[17:12] ^ addr[23:18] ^ addr[29:24];
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic wro_pkg::rd_req_t to_rd(input wro_pkg::wr_req_t w);
        wro_pkg::rd_req_t r;
        wro_pkg::data_t unused;
        {r, unused} = w;
        return r;
    endfunction

    function automatic wro_pkg::wr_req_t to_wr(input wro_pkg::rd_req_t r);
        return {r, wro_pkg::data_t'(0)};
    endfunction

    // ==============================
    // Compare tasks
    // ==============================

    task automatic compare_rd_req(input string name, input wro_pkg::rd_req_t got,
                                  input wro_pkg::rd_req_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_wr_req(input string name, input wro_pkg::wr_req_t got,
                                  input wro_pkg::wr_req_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_rsp(input string name, input wro_pkg::rsp_t got,
                               input wro_pkg::rsp_t exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            value_errors++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // Pick a free tag and a colliding address, valid stays low if no tag is free
    task automatic new_request(input int ch, output wro_pkg::wr_req_t r);
        int start;
        int t;
        int i;
        r = '0;
        start = rand_below(wro_pkg::N_TAGS);
        for (i = 0; i < wro_pkg::N_TAGS; i++)
        begin
            t = (start + i) % wro_pkg::N_TAGS;
            if (!r.valid && !tag_used[ch][t])
            begin
                tag_used[ch][t] = 1'b1;
                r.valid = 1'b1;
                r.tag = wro_pkg::tag_t'(t);
            end
        end
        // Only a few line and fold bits vary, so hashes collide often
        r.addr = wro_pkg::addr_t'($random(seed)) & 32'h0100_30ff;
        r.check_order = ordered_on && (rand_below(2) == 1);
        r.data = (ch == 1) ? wro_pkg::data_t'($random(seed)) : '0;
    endtask

    // ==============================
    // One clock cycle of checking, model update and stimulus
    // ==============================

    task automatic run_cycle();
        wro_pkg::wr_req_t head [2];
        wro_pkg::wr_req_t up_cur [2];
        wro_pkg::wr_req_t next_req [2];
        wro_pkg::rsp_t rsp [2];
        wro_pkg::rsp_t next_rsp [2];
        wro_pkg::hash_t h [2];
        bit head_valid [2];
        bit hold [2];
        bit exp_issue [2];
        bit got_issue [2];
        bit pulse [2];
        bit next_pulse [2];
        int ch;
        int i;
        int found;

        // Outputs are sampled mid-cycle where they are settled
        @(negedge clk);
        cycle++;
        got_issue[0] = dn_rd_req.valid;
        got_issue[1] = dn_wr_req.valid;
        last_ready[0] = up_rd_ready;
        last_ready[1] = up_wr_ready;
        rsp[0] = dn_rd_rsp;
        rsp[1] = dn_wr_rsp;
        pulse[0] = dn_rd_credit;
        pulse[1] = dn_wr_credit;
        up_cur[0] = to_wr(up_rd_req);
        up_cur[1] = up_wr_req;

        // The oldest accepted request not yet issued is the head
        for (ch = 0; ch < 2; ch++)
        begin
            head_valid[ch] = (req_q[ch].size() > 0);
            head[ch] = head_valid[ch] ? req_q[ch][0] : '0;
            h[ch] = line_hash(head[ch].addr);
            hold[ch] = head_valid[ch] && head[ch].check_order &&
                       (busy[0][h[ch]] || busy[1][h[ch]]);
        end
        // A write loses the tie against a read head at the same hash
        if (head_valid[0] && head_valid[1] && h[0] == h[1] && head[1].check_order)
            hold[1] = 1'b1;

        for (ch = 0; ch < 2; ch++)
            exp_issue[ch] = head_valid[ch] && !hold[ch] && (credits[ch] > 0);

        compare_bit("dn_rd_req.valid", got_issue[0], exp_issue[0]);
        compare_bit("dn_wr_req.valid", got_issue[1], exp_issue[1]);
        if (exp_issue[0])
            compare_rd_req("dn_rd_req", dn_rd_req, to_rd(head[0]));
        if (exp_issue[1])
            compare_wr_req("dn_wr_req", dn_wr_req, head[1]);
        compare_bit("rd_conflict_event", rd_conflict_event, hold_prev[0]);
        compare_bit("wr_conflict_event", wr_conflict_event, hold_prev[1]);
        compare_bit("up_rd_ready", last_ready[0], !head_valid[0] || exp_issue[0]);
        compare_bit("up_wr_ready", last_ready[1], !head_valid[1] || exp_issue[1]);
        compare_rsp("up_rd_rsp", up_rd_rsp, rsp[0]);
        compare_rsp("up_wr_rsp", up_wr_rsp, rsp[1]);

        for (ch = 0; ch < 2; ch++)
        begin
            hold_prev[ch] = hold[ch];
            if (got_issue[ch] && !head_valid[ch])
            begin
                other_errors++;
                $display("[ERROR] %0t channel %0d sent a request that was never accepted",
                         $time, ch);
            end
            // A response clears the bit of its hash and frees the tag
            if (rsp[ch].valid)
            begin
                busy[ch][tag_hash[ch][rsp[ch].tag]] = 1'b0;
                tag_used[ch][rsp[ch].tag] = 1'b0;
            end
            // Insert after remove, so a new issue to the same hash stays busy
            if (got_issue[ch] && head_valid[ch])
            begin
                busy[ch][h[ch]] = 1'b1;
                tag_hash[ch][head[ch].tag] = h[ch];
                void'(req_q[ch].pop_front());
                issued[ch]++;
                credits[ch]--;
                owed[ch]++;
                rsp_due[ch].push_back(cycle + 1 + rand_below(8));
                rsp_tag[ch].push_back(head[ch].tag);
            end
            if (pulse[ch])
                credits[ch]++;
            if (up_cur[ch].valid && last_ready[ch])
                req_q[ch].push_back(up_cur[ch]);

            // Requester holds a request until ready takes it
            if (up_cur[ch].valid && !last_ready[ch])
                next_req[ch] = up_cur[ch];
            else if (gen_on && presented[ch] < present_limit && rand_below(4) != 0)
                new_request(ch, next_req[ch]);
            else
                next_req[ch] = '0;
            if (next_req[ch].valid && !(up_cur[ch].valid && !last_ready[ch]))
                presented[ch]++;

            // Memory answers the first response that has come due
            next_rsp[ch] = '0;
            found = -1;
            for (i = 0; i < rsp_due[ch].size(); i++)
            begin
                if (found < 0 && rsp_due[ch][i] <= cycle + 1)
                    found = i;
            end
            if (found >= 0)
            begin
                next_rsp[ch].valid = 1'b1;
                next_rsp[ch].tag = rsp_tag[ch][found];
                rsp_due[ch].delete(found);
                rsp_tag[ch].delete(found);
            end

            next_pulse[ch] = credits_on && (owed[ch] > 0) && (rand_below(3) == 0);
            if (next_pulse[ch])
                owed[ch]--;
        end

        @(posedge clk);
        up_rd_req <= to_rd(next_req[0]);
        up_wr_req <= next_req[1];
        dn_rd_rsp <= next_rsp[0];
        dn_wr_rsp <= next_rsp[1];
        dn_rd_credit <= next_pulse[0];
        dn_wr_credit <= next_pulse[1];
    endtask

    function automatic bit work_pending();
        bit p;
        p = up_rd_req.valid || up_wr_req.valid;
        for (int ch = 0; ch < 2; ch++)
        begin
            if (req_q[ch].size() != 0 || rsp_due[ch].size() != 0 || owed[ch] != 0)
                p = 1'b1;
        end
        return p;
    endfunction

    // ==============================
    // Test sequence
    // ==============================

    initial
    begin
        up_rd_req <= '0;
        up_wr_req <= '0;
        dn_rd_credit <= 1'b0;
        dn_wr_credit <= 1'b0;
        dn_rd_rsp <= '0;
        dn_wr_rsp <= '0;
        reset <= 1'b1;
        credits[0] = wro_pkg::CREDITS_INIT;
        credits[1] = wro_pkg::CREDITS_INIT;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // No credits come back, so each channel must stop after its initial credits
        gen_on = 1'b1;
        ordered_on = 1'b0;
        credits_on = 1'b0;
        present_limit = DIRECTED_REQS;
        repeat (DIRECTED_CYCLES) run_cycle();
        if (issued[0] != wro_pkg::CREDITS_INIT || issued[1] != wro_pkg::CREDITS_INIT)
        begin
            other_errors++;
            $display("[ERROR] %0t without credit returns %0d reads and %0d writes issued",
                     $time, issued[0], issued[1]);
        end
        compare_bit("up_rd_ready", last_ready[0], 1'b0);
        compare_bit("up_wr_ready", last_ready[1], 1'b0);

        // Mixed ordering with credits flowing again
        ordered_on = 1'b1;
        credits_on = 1'b1;
        present_limit = 2 * RANDOM_CYCLES;
        repeat (RANDOM_CYCLES) run_cycle();

        gen_on = 1'b0;
        while (work_pending())
            run_cycle();

        $display("Checks finished: %0d value errors, %0d other errors, %0d assertion failures",
                 value_errors, other_errors, assert_fail_count);
        if (value_errors + other_errors + assert_fail_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog sized from the random run plus a margin
    initial
    begin
        #((RANDOM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles",
                 RANDOM_CYCLES + MARGIN_CYCLES);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== all.f ====
hdl/wro_pkg.sv
hdl/wro_req_buffer.sv
hdl/wro_busy_filter.sv
hdl/wro_tag_heap.sv
hdl/wro_credit_counter.sv
hdl/wro_issue_ctrl.sv
hdl/wro_shim.sv
testbench/wro_assertions.sv
testbench/wro_tb.sv

// ==== Bender.yml ====
package:
  name: wro_shim

sources:
  - hdl/wro_pkg.sv
  - hdl/wro_req_buffer.sv
  - hdl/wro_busy_filter.sv
  - hdl/wro_tag_heap.sv
  - hdl/wro_credit_counter.sv
  - hdl/wro_issue_ctrl.sv
  - hdl/wro_shim.sv
  - target: test
    files:
      - testbench/wro_assertions.sv
      - testbench/wro_tb.sv
